// ==== verilog/manycore_link_pkg.sv ====
package manycore_link_pkg;

  // request field widths
  localparam int addr_width_lp = 28;
  localparam int data_width_lp = 32;
  localparam int cord_width_lp = 7;

  // stage of the attached ruche link
  // an odd stage means the payload arrives bitwise inverted
  localparam int ruche_stage_lp = 1;

  typedef enum logic [1:0] {
    op_load   = 2'b00,
    op_store  = 2'b01,
    op_amo    = 2'b10,
    op_config = 2'b11
  } manycore_op_e;

  // single-beat request packet, 90 bits
  typedef struct packed {
    manycore_op_e             op;
    logic [addr_width_lp-1:0] addr;
    logic [data_width_lp-1:0] data;
    logic [cord_width_lp-1:0] src_x;
    logic [cord_width_lp-1:0] src_y;
    logic [cord_width_lp-1:0] dst_x;
    logic [cord_width_lp-1:0] dst_y;
  } manycore_packet_s;

  // forward half of a link
  // ready travels on its own wire in the reverse direction
  typedef struct packed {
    logic             valid;
    manycore_packet_s packet;
  } manycore_link_s;

  // source tag for the merge onto the proc link
  typedef enum logic {
    grant_hor   = 1'b0,
    grant_ruche = 1'b1
  } arb_grant_e;

endpackage

// ==== verilog/link_fifo.sv ====
`timescale 1ns/1ps

module link_fifo #(
  parameter type payload_t = manycore_link_pkg::manycore_packet_s
) (
  input  logic     clk_i,
  input  logic     rst_n_i,

  input  logic     valid_i,
  input  payload_t data_i,
  output logic     ready_o,

  output logic     valid_o,
  output payload_t data_o,
  input  logic     yumi_ready_i
);

  payload_t   mem_r [2];
  logic       head_r;
  logic       tail_r;
  logic [1:0] count_r;
  logic       enq;
  logic       deq;

  // ready comes from occupancy only
  assign ready_o = (count_r != 2'd2);
  assign valid_o = (count_r != 2'd0);
  assign data_o  = mem_r[head_r];

  assign enq = valid_i & ready_o;
  assign deq = valid_o & yumi_ready_i;

  always_ff @(posedge clk_i) begin
    if (enq) begin
      mem_r[tail_r] <= data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      head_r  <= 1'b0;
      tail_r  <= 1'b0;
      count_r <= 2'd0;
    end else begin
      if (enq) begin
        tail_r <= ~tail_r;
      end
      if (deq) begin
        head_r <= ~head_r;
      end
      // simultaneous enq and deq keeps the count
      case ({enq, deq})
        2'b10:   count_r <= count_r + 2'd1;
        2'b01:   count_r <= count_r - 2'd1;
        default: count_r <= count_r;
      endcase
    end
  end

  // count and pointers agree, so a write into a full buffer shows up as overrun
  a_no_write_when_full: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (count_r != 2'd3) && ((count_r == 2'd1) == (head_r != tail_r))
  );

  // head entry held under back-pressure
  a_out_stable: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (valid_o && !yumi_ready_i) |=> (valid_o && $stable(data_o))
  );

endmodule

// ==== verilog/ruche_link_recv.sv ====
`timescale 1ns/1ps

module ruche_link_recv #(
  parameter bit invert_p = 1'b0
) (
  input  logic                            clk_i,
  input  logic                            rst_n_i,

  input  manycore_link_pkg::manycore_link_s ruche_link_i,
  output logic                            ruche_ready_o,

  output manycore_link_pkg::manycore_link_s buf_link_o,
  input  logic                            buf_ready_i
);

  import manycore_link_pkg::*;

  manycore_packet_s fixed_packet;
  manycore_packet_s buf_packet;
  logic             buf_valid;

  // undo the odd-stage inversion, valid is sent true
  always_comb begin
    if (invert_p) begin
      fixed_packet = manycore_packet_s'(~ruche_link_i.packet);
    end else begin
      fixed_packet = ruche_link_i.packet;
    end
  end

  link_fifo #(
    .payload_t(manycore_packet_s)
  ) ruche_fifo (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .valid_i     (ruche_link_i.valid),
    .data_i      (fixed_packet),
    .ready_o     (ruche_ready_o),
    .valid_o     (buf_valid),
    .data_o      (buf_packet),
    .yumi_ready_i(buf_ready_i)
  );

  assign buf_link_o = '{valid: buf_valid, packet: buf_packet};

  // polarity restored before storage, so buffered opcodes are legal
  a_legal_op: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    buf_valid |-> (buf_packet.op inside {op_load, op_store, op_amo, op_config})
  );

endmodule

// ==== verilog/packet_arbiter.sv ====
`timescale 1ns/1ps

module packet_arbiter (
  input  logic                              clk_i,
  input  logic                              rst_n_i,

  input  manycore_link_pkg::manycore_link_s hor_link_i,
  input  manycore_link_pkg::manycore_link_s ruche_link_i,
  output logic                              hor_ready_o,
  output logic                              ruche_ready_o,

  output manycore_link_pkg::manycore_link_s proc_link_o,
  input  logic                              proc_ready_i
);

  import manycore_link_pkg::*;

  arb_grant_e       ptr_r;
  logic             out_valid_r;
  manycore_packet_s out_packet_r;
  logic             load_ok;
  logic             hor_take;
  logic             ruche_take;

  // output register is free or drains on this edge
  assign load_ok = ~out_valid_r | proc_ready_i;

  // a source loses only when the other is valid and holds priority
  assign hor_ready_o   = load_ok & (~ruche_link_i.valid | (ptr_r == grant_hor));
  assign ruche_ready_o = load_ok & (~hor_link_i.valid | (ptr_r == grant_ruche));

  assign hor_take   = hor_link_i.valid & hor_ready_o;
  assign ruche_take = ruche_link_i.valid & ruche_ready_o;

  // priority pointer
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ptr_r <= grant_hor;
    end else if (hor_take) begin
      ptr_r <= grant_ruche;
    end else if (ruche_take) begin
      ptr_r <= grant_hor;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_valid_r <= 1'b0;
    end else if (hor_take | ruche_take) begin
      out_valid_r <= 1'b1;
    end else if (proc_ready_i) begin
      out_valid_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (hor_take) begin
      out_packet_r <= hor_link_i.packet;
    end else if (ruche_take) begin
      out_packet_r <= ruche_link_i.packet;
    end
  end

  assign proc_link_o = '{valid: out_valid_r, packet: out_packet_r};

  a_one_grant: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    $onehot0({hor_take, ruche_take})
  );

  // stalled output keeps its packet until the host takes it
  a_stall_stable: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (out_valid_r && !proc_ready_i) |=> (out_valid_r && $stable(out_packet_r))
  );

endmodule

// ==== verilog/hor_io_router.sv ====
`timescale 1ns/1ps

module hor_io_router (
  input  logic                              clk_i,
  input  logic                              rst_n_i,

  input  manycore_link_pkg::manycore_link_s hor_link_i,
  output logic                              hor_ready_o,

  input  manycore_link_pkg::manycore_link_s ruche_link_i,
  output logic                              ruche_ready_o,

  output manycore_link_pkg::manycore_link_s proc_link_o,
  input  logic                              proc_ready_i
);

  import manycore_link_pkg::*;

  manycore_link_s   hor_buf_link;
  logic             hor_buf_ready;
  logic             hor_buf_valid;
  manycore_packet_s hor_buf_packet;
  manycore_link_s   ruche_buf_link;
  logic             ruche_buf_ready;

  // local horizontal link, payload kept as sent
  link_fifo #(
    .payload_t(manycore_packet_s)
  ) hor_fifo (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .valid_i     (hor_link_i.valid),
    .data_i      (hor_link_i.packet),
    .ready_o     (hor_ready_o),
    .valid_o     (hor_buf_valid),
    .data_o      (hor_buf_packet),
    .yumi_ready_i(hor_buf_ready)
  );

  assign hor_buf_link = '{valid: hor_buf_valid, packet: hor_buf_packet};

  ruche_link_recv #(
    .invert_p(bit'(ruche_stage_lp % 2))
  ) ruche_recv (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .ruche_link_i (ruche_link_i),
    .ruche_ready_o(ruche_ready_o),
    .buf_link_o   (ruche_buf_link),
    .buf_ready_i  (ruche_buf_ready)
  );

  packet_arbiter arb (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .hor_link_i   (hor_buf_link),
    .ruche_link_i (ruche_buf_link),
    .hor_ready_o  (hor_buf_ready),
    .ruche_ready_o(ruche_buf_ready),
    .proc_link_o  (proc_link_o),
    .proc_ready_i (proc_ready_i)
  );

endmodule

// ==== bench/tb_check_tasks.svh ====
`ifndef TB_CHECK_TASKS_SVH
`define TB_CHECK_TASKS_SVH

int          err_count  = 0;
logic [31:0] lfsr_state = 32'd95249;

// galois form, taps 32 22 2 1
function automatic logic lfsr_bit();
  logic out;
  out = lfsr_state[0];
  lfsr_state = lfsr_state >> 1;
  if (out) begin
    lfsr_state = lfsr_state ^ 32'h8020_0003;
  end
  return out;
endfunction

function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    v = {v[30:0], lfsr_bit()};
  end
  return v;
endfunction

// src_x tags the input port the packet was sent on
function automatic manycore_packet_s make_packet(input logic [cord_width_lp-1:0] sx);
  manycore_packet_s p;
  logic [31:0]      r;
  r = rand_bits(2);
  p.op = manycore_op_e'(r[1:0]);
  r = rand_bits(addr_width_lp);
  p.addr = r[addr_width_lp-1:0];
  p.data = rand_bits(data_width_lp);
  p.src_x = sx;
  r = rand_bits(cord_width_lp);
  p.src_y = r[cord_width_lp-1:0];
  r = rand_bits(cord_width_lp);
  p.dst_x = r[cord_width_lp-1:0];
  r = rand_bits(cord_width_lp);
  p.dst_y = r[cord_width_lp-1:0];
  return p;
endfunction

// ready is stable between edges, so it is read at the falling edge
task automatic send_hor(input manycore_packet_s pkt);
  @(negedge clk_i);
  hor_link_i = '{valid: 1'b1, packet: pkt};
  while (!hor_ready_o) @(negedge clk_i);
  @(posedge clk_i);
  hor_sent_q.push_back(pkt);
endtask

// odd ruche stage sends the payload inverted
task automatic send_ruche(input manycore_packet_s pkt);
  @(negedge clk_i);
  ruche_link_i.valid  = 1'b1;
  ruche_link_i.packet = (ruche_stage_lp % 2 == 1) ? ~pkt : pkt;
  while (!ruche_ready_o) @(negedge clk_i);
  @(posedge clk_i);
  ruche_sent_q.push_back(pkt);
endtask

task automatic check_packet(input string name, input manycore_packet_s got,
                            input manycore_packet_s exp);
  if (got !== exp) begin
    err_count++;
    $display("[FAIL] %s: got %h expected %h", name, got, exp);
  end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    err_count++;
    $display("[FAIL] %s: got %h expected %h", name, got, exp);
  end
endtask

task automatic report_error(input string msg);
  err_count++;
  $display("error: %s", msg);
endtask

`endif

// ==== bench/tb_hor_io_router.sv ====
`timescale 1ns/1ps

module tb_hor_io_router;

  import manycore_link_pkg::*;

  // estimated length of each test in cycles
  localparam int reset_len_c = 8;
  localparam int hor_len_c   = 30;
  localparam int ruche_len_c = 30;
  localparam int rr_len_c    = 40;
  localparam int bp_len_c    = 50;
  localparam int cycle_limit_c =
    (reset_len_c + hor_len_c + ruche_len_c + rr_len_c + bp_len_c) * 4;

  localparam logic [cord_width_lp-1:0] hor_src_x_c   = 7'h11;
  localparam logic [cord_width_lp-1:0] ruche_src_x_c = 7'h22;

  logic             clk_i = 1'b0;
  logic             rst_n_i;
  manycore_link_s   hor_link_i;
  logic             hor_ready_o;
  manycore_link_s   ruche_link_i;
  logic             ruche_ready_o;
  manycore_link_s   proc_link_o;
  logic             proc_ready_i;

  manycore_packet_s hor_sent_q[$];
  manycore_packet_s ruche_sent_q[$];
  manycore_packet_s out_q[$];
  int               cycle_count  = 0;
  int               tests_run    = 0;
  int               tests_failed = 0;

  `include "tb_check_tasks.svh"

  hor_io_router hor_io_router_inst (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .hor_link_i   (hor_link_i),
    .hor_ready_o  (hor_ready_o),
    .ruche_link_i (ruche_link_i),
    .ruche_ready_o(ruche_ready_o),
    .proc_link_o  (proc_link_o),
    .proc_ready_i (proc_ready_i)
  );

  always #50 clk_i = ~clk_i;

  // every proc link handshake
  always @(posedge clk_i) begin
    if (proc_link_o.valid && proc_ready_i) begin
      out_q.push_back(proc_link_o.packet);
    end
  end

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit_c) begin
      $display("error: run stopped after %0d cycles, the DUT did not finish", cycle_count);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  task automatic gen_packets(input int n, input logic [cord_width_lp-1:0] sx,
                             output manycore_packet_s q[$]);
    q = {};
    for (int i = 0; i < n; i++) begin
      q.push_back(make_packet(sx));
    end
  endtask

  task automatic send_hor_stream(input manycore_packet_s pkts[$]);
    foreach (pkts[i]) send_hor(pkts[i]);
    @(negedge clk_i);
    hor_link_i.valid = 1'b0;
  endtask

  task automatic send_ruche_stream(input manycore_packet_s pkts[$]);
    foreach (pkts[i]) send_ruche(pkts[i]);
    @(negedge clk_i);
    ruche_link_i.valid = 1'b0;
  endtask

  task automatic clear_queues();
    hor_sent_q   = {};
    ruche_sent_q = {};
    out_q        = {};
  endtask

  // a few idle cycles catch duplicated packets
  task automatic wait_outputs(input int n);
    while (out_q.size() < n) @(negedge clk_i);
    repeat (3) @(negedge clk_i);
    if (out_q.size() != n) begin
      report_error($sformatf("expected %0d packets on proc_link_o, saw %0d", n, out_q.size()));
    end
  endtask

  task automatic check_stream(input string name, input logic [cord_width_lp-1:0] sx,
                              input manycore_packet_s exp_q[$]);
    manycore_packet_s got_q[$];
    foreach (out_q[i]) begin
      if (out_q[i].src_x == sx) got_q.push_back(out_q[i]);
    end
    if (got_q.size() != exp_q.size()) begin
      report_error($sformatf("%s: %0d packets sent, %0d came out", name, exp_q.size(),
                             got_q.size()));
    end else begin
      foreach (exp_q[i]) check_packet($sformatf("%s[%0d]", name, i), got_q[i], exp_q[i]);
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    tests_run++;
    if (err_count != errs_before) begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, err_count - errs_before);
    end else begin
      $display("test %s: ok", name);
    end
  endtask

  task automatic test_reset_state();
    int errs;
    errs = err_count;
    rst_n_i = 1'b0;
    for (int i = 0; i < 4; i++) begin
      @(negedge clk_i);
      check_bit("proc_link_o.valid", proc_link_o.valid, 1'b0);
      check_bit("hor_ready_o", hor_ready_o, 1'b1);
      check_bit("ruche_ready_o", ruche_ready_o, 1'b1);
      // held low for three cycles, the fourth look is after release
      if (i == 2) rst_n_i = 1'b1;
    end
    finish_test("reset_state", errs);
  endtask

  task automatic test_hor_pass();
    int               errs;
    manycore_packet_s hq[$];
    errs = err_count;
    clear_queues();
    gen_packets(8, hor_src_x_c, hq);
    send_hor_stream(hq);
    wait_outputs(8);
    check_stream("hor_packet", hor_src_x_c, hq);
    finish_test("hor_pass_through", errs);
  endtask

  task automatic test_ruche_polarity();
    int               errs;
    manycore_packet_s rq[$];
    errs = err_count;
    clear_queues();
    gen_packets(8, ruche_src_x_c, rq);
    send_ruche_stream(rq);
    wait_outputs(8);
    check_stream("ruche_packet", ruche_src_x_c, rq);
    finish_test("ruche_polarity", errs);
  endtask

  task automatic test_round_robin();
    int               errs;
    manycore_packet_s hq[$];
    manycore_packet_s rq[$];
    arb_grant_e       exp_src;
    errs = err_count;
    rst_n_i = 1'b0;
    repeat (3) @(negedge clk_i);
    rst_n_i = 1'b1;
    clear_queues();
    gen_packets(6, hor_src_x_c, hq);
    gen_packets(6, ruche_src_x_c, rq);
    fork
      send_hor_stream(hq);
      send_ruche_stream(rq);
    join
    wait_outputs(12);
    // pointer starts at hor after reset, contended grants alternate
    exp_src = grant_hor;
    foreach (out_q[i]) begin
      check_bit($sformatf("source_is_ruche[%0d]", i), out_q[i].src_x == ruche_src_x_c,
                exp_src == grant_ruche);
      exp_src = (exp_src == grant_hor) ? grant_ruche : grant_hor;
    end
    check_stream("hor_packet", hor_src_x_c, hq);
    check_stream("ruche_packet", ruche_src_x_c, rq);
    finish_test("round_robin", errs);
  endtask

  task automatic test_back_pressure();
    int               errs;
    manycore_packet_s hq[$];
    manycore_packet_s rq[$];
    errs = err_count;
    clear_queues();
    gen_packets(4, hor_src_x_c, hq);
    gen_packets(4, ruche_src_x_c, rq);
    @(negedge clk_i);
    proc_ready_i = 1'b0;
    fork
      send_hor_stream(hq);
      send_ruche_stream(rq);
      begin
        repeat (10) @(negedge clk_i);
        check_bit("hor_ready_o", hor_ready_o, 1'b0);
        check_bit("ruche_ready_o", ruche_ready_o, 1'b0);
        check_bit("proc_link_o.valid", proc_link_o.valid, 1'b1);
        // last merge ended on ruche, so the stalled register holds the first hor packet
        check_packet("proc_link_o.packet", proc_link_o.packet, hq[0]);
        // two slots per buffer plus the output register
        if (hor_sent_q.size() + ruche_sent_q.size() != 5) begin
          report_error($sformatf("stalled inputs took %0d packets instead of 5",
                                 hor_sent_q.size() + ruche_sent_q.size()));
        end
        proc_ready_i = 1'b1;
      end
    join
    wait_outputs(8);
    check_stream("hor_packet", hor_src_x_c, hq);
    check_stream("ruche_packet", ruche_src_x_c, rq);
    finish_test("back_pressure", errs);
  endtask

  initial begin
    rst_n_i      = 1'b0;
    hor_link_i   = '0;
    ruche_link_i = '0;
    proc_ready_i = 1'b1;
    test_reset_state();
    test_hor_pass();
    test_ruche_polarity();
    test_round_robin();
    test_back_pressure();
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, err_count);
    if (err_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+bench
verilog/manycore_link_pkg.sv
verilog/link_fifo.sv
verilog/ruche_link_recv.sv
verilog/packet_arbiter.sv
verilog/hor_io_router.sv
bench/tb_hor_io_router.sv

// ==== Makefile ====
# Verilator build for the horizontal I/O router testbench
# override any variable on the command line, e.g. make run LOG=out.log

VERILATOR ?= verilator
TOP       ?= tb_hor_io_router
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Simulation finished: PASS
VFLAGS    ?= --binary --timing --assert

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "pass message found in $(LOG)"; \
	else \
		echo "pass message missing from $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
